// ==== fp_cfg_pkg.sv ====
/*
 * Single-precision data path configuration
 * Word width, register count and field widths
 * Typedefs for register values and register addresses
 */

package fp_cfg_pkg;

  // Only single precision is built
  localparam int unsigned FLEN      = 32;
  localparam int unsigned NUM_FREGS = 32;
  localparam int unsigned FREG_AW   = 5;

  // IEEE-754 binary32 field widths
  localparam int unsigned EXP_W  = 8;
  localparam int unsigned MANT_W = 23;

  // One register value, also used for integer-side data
  typedef logic [FLEN-1:0] fp_word_t;

  // Register address, FP or integer destination
  typedef logic [FREG_AW-1:0] freg_addr_t;

  // Canonical quiet NaN
  // Positive sign, all-ones exponent, only the quiet bit set
  localparam fp_word_t CANON_NAN = 32'h7fc0_0000;

endpackage

// ==== fp_isa_pkg.sv ====
/*
 * F-extension encodings for the non-arithmetic operations
 * Major opcode, funct7 and funct3 constants
 * Operation enum and FCLASS mask bit positions
 */

package fp_isa_pkg;

  // Major opcode for OP-FP
  localparam logic [6:0] OPC_OP_FP = 7'b1010011;

  // funct7 with fmt = S in the low two bits
  localparam logic [6:0] FUNCT7_SGNJ   = 7'b0010000;
  localparam logic [6:0] FUNCT7_MINMAX = 7'b0010100;
  localparam logic [6:0] FUNCT7_CMP    = 7'b1010000;
  // FMV.X.W and FCLASS.S, split by funct3
  localparam logic [6:0] FUNCT7_MV_X_W = 7'b1110000;
  localparam logic [6:0] FUNCT7_MV_W_X = 7'b1111000;

  // funct3 per group
  localparam logic [2:0] F3_SGNJ   = 3'b000;
  localparam logic [2:0] F3_SGNJN  = 3'b001;
  localparam logic [2:0] F3_SGNJX  = 3'b010;
  localparam logic [2:0] F3_MIN    = 3'b000;
  localparam logic [2:0] F3_MAX    = 3'b001;
  localparam logic [2:0] F3_FLE    = 3'b000;
  localparam logic [2:0] F3_FLT    = 3'b001;
  localparam logic [2:0] F3_FEQ    = 3'b010;
  localparam logic [2:0] F3_FMV    = 3'b000;
  localparam logic [2:0] F3_FCLASS = 3'b001;

  // Decoded operation
  typedef enum logic [3:0] {
    OP_NONE,
    OP_FSGNJ,
    OP_FSGNJN,
    OP_FSGNJX,
    OP_FMIN,
    OP_FMAX,
    OP_FEQ,
    OP_FLT,
    OP_FLE,
    OP_FCLASS,
    OP_FMV_X_W,
    OP_FMV_W_X
  } fp_op_e;

  // FCLASS.S result bits, RISC-V order
  localparam int unsigned CLASS_NEG_INF     = 0;
  localparam int unsigned CLASS_NEG_NORM    = 1;
  localparam int unsigned CLASS_NEG_SUBNORM = 2;
  localparam int unsigned CLASS_NEG_ZERO    = 3;
  localparam int unsigned CLASS_POS_ZERO    = 4;
  localparam int unsigned CLASS_POS_SUBNORM = 5;
  localparam int unsigned CLASS_POS_NORM    = 6;
  localparam int unsigned CLASS_POS_INF     = 7;
  localparam int unsigned CLASS_SNAN        = 8;
  localparam int unsigned CLASS_QNAN        = 9;

endpackage

// ==== fp_regfile.sv ====
/*
 * FP register file on flip-flops
 * 32 x 32-bit registers, reset to zero
 * Three combinational read ports, one write port
 */

`timescale 1ns/1ps

module fp_regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  fp_cfg_pkg::freg_addr_t raddr_a_i,
  input  fp_cfg_pkg::freg_addr_t raddr_b_i,
  input  fp_cfg_pkg::freg_addr_t raddr_c_i,
  output fp_cfg_pkg::fp_word_t   rdata_a_o,
  output fp_cfg_pkg::fp_word_t   rdata_b_o,
  output fp_cfg_pkg::fp_word_t   rdata_c_o,

  input  fp_cfg_pkg::freg_addr_t waddr_i,
  input  fp_cfg_pkg::fp_word_t   wdata_i,
  input  logic                   we_i
);
  import fp_cfg_pkg::*;

  fp_word_t             rf_q [NUM_FREGS];
  logic [NUM_FREGS-1:0] we_dec;

  // One-hot write enables
  always_comb begin
    for (int unsigned i = 0; i < NUM_FREGS; i++) begin
      we_dec[i] = we_i && (waddr_i == freg_addr_t'(i));
    end
  end

  // f0 is writable like any other entry
  for (genvar i = 0; i < NUM_FREGS; i++) begin : g_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_dec[i]) begin
        rf_q[i] <= wdata_i;
      end
    end
  end

  // Plain array reads, no bypass here
  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];
  assign rdata_c_o = rf_q[raddr_c_i];

endmodule

// ==== fp_decoder.sv ====
/*
 * Instruction decoder for the OP-FP non-arithmetic group
 * Operation select, register fields, destination kind, illegal flag
 */

`timescale 1ns/1ps

module fp_decoder (
  input  logic [31:0]            instr_i,
  output fp_isa_pkg::fp_op_e     op_o,
  output fp_cfg_pkg::freg_addr_t rs1_o,
  output fp_cfg_pkg::freg_addr_t rs2_o,
  output fp_cfg_pkg::freg_addr_t rd_o,
  output logic                   rd_is_fp_o,
  output logic                   illegal_o
);
  import fp_cfg_pkg::*;
  import fp_isa_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       rs2_zero;

  // R-type fields
  assign opcode   = instr_i[6:0];
  assign rd_o     = instr_i[11:7];
  assign funct3   = instr_i[14:12];
  assign rs1_o    = instr_i[19:15];
  assign rs2_o    = instr_i[24:20];
  assign funct7   = instr_i[31:25];
  assign rs2_zero = (instr_i[24:20] == 5'd0);

  // Operation select
  always_comb begin
    op_o = OP_NONE;
    if (opcode == OPC_OP_FP) begin
      case (funct7)
        FUNCT7_SGNJ: begin
          case (funct3)
            F3_SGNJ:  op_o = OP_FSGNJ;
            F3_SGNJN: op_o = OP_FSGNJN;
            F3_SGNJX: op_o = OP_FSGNJX;
            default:  op_o = OP_NONE;
          endcase
        end
        FUNCT7_MINMAX: begin
          case (funct3)
            F3_MIN:  op_o = OP_FMIN;
            F3_MAX:  op_o = OP_FMAX;
            default: op_o = OP_NONE;
          endcase
        end
        FUNCT7_CMP: begin
          case (funct3)
            F3_FEQ:  op_o = OP_FEQ;
            F3_FLT:  op_o = OP_FLT;
            F3_FLE:  op_o = OP_FLE;
            default: op_o = OP_NONE;
          endcase
        end
        // Single-operand forms need rs2 = 0
        FUNCT7_MV_X_W: begin
          if (rs2_zero && funct3 == F3_FMV) begin
            op_o = OP_FMV_X_W;
          end else if (rs2_zero && funct3 == F3_FCLASS) begin
            op_o = OP_FCLASS;
          end
        end
        FUNCT7_MV_W_X: begin
          if (rs2_zero && funct3 == F3_FMV) begin
            op_o = OP_FMV_W_X;
          end
        end
        default: op_o = OP_NONE;
      endcase
    end
  end

  // Compares, classify and FMV.X.W write the integer side
  always_comb begin
    case (op_o)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX,
      OP_FMIN, OP_FMAX, OP_FMV_W_X: rd_is_fp_o = 1'b1;
      default:                      rd_is_fp_o = 1'b0;
    endcase
  end

  assign illegal_o = (op_o == OP_NONE);

endmodule

// ==== fp_issue_stage.sv ====
/*
 * Operand forwarding and execute-stage pipeline register
 * Bypass from the instruction in execute, FMV.W.X operand select
 */

`timescale 1ns/1ps

module fp_issue_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Decode stage
  input  logic                   valid_i,
  input  fp_isa_pkg::fp_op_e     op_i,
  input  fp_cfg_pkg::freg_addr_t rs1_i,
  input  fp_cfg_pkg::freg_addr_t rs2_i,
  input  fp_cfg_pkg::freg_addr_t rd_i,
  input  logic                   rd_is_fp_i,
  input  logic                   illegal_i,
  input  fp_cfg_pkg::fp_word_t   rf_a_i,
  input  fp_cfg_pkg::fp_word_t   rf_b_i,
  input  fp_cfg_pkg::fp_word_t   int_operand_i,

  // Result of the instruction now in execute
  input  fp_cfg_pkg::fp_word_t   result_i,

  // Execute stage
  output logic                   ex_valid_o,
  output fp_isa_pkg::fp_op_e     ex_op_o,
  output fp_cfg_pkg::fp_word_t   ex_a_o,
  output fp_cfg_pkg::fp_word_t   ex_b_o,
  output fp_cfg_pkg::freg_addr_t ex_rd_o,
  output logic                   ex_rd_is_fp_o,
  output logic                   fwd_rf_we_o
);
  import fp_cfg_pkg::*;
  import fp_isa_pkg::*;

  logic       ex_valid_q;
  fp_op_e     ex_op_q;
  fp_word_t   ex_a_q;
  fp_word_t   ex_b_q;
  freg_addr_t ex_rd_q;
  logic       ex_rd_is_fp_q;

  logic       ex_writes_fp;
  logic       fwd_a;
  logic       fwd_b;
  logic       accept;
  fp_word_t   opnd_a;
  fp_word_t   opnd_b;

  // Execute stage will write the RF at the end of this cycle
  assign ex_writes_fp = ex_valid_q & ex_rd_is_fp_q;

  // Bypass hits, per source
  assign fwd_a = ex_writes_fp && (ex_rd_q == rs1_i);
  assign fwd_b = ex_writes_fp && (ex_rd_q == rs2_i);

  always_comb begin
    opnd_a = fwd_a ? result_i : rf_a_i;
    opnd_b = fwd_b ? result_i : rf_b_i;
    // Integer source replaces rs1
    if (op_i == OP_FMV_W_X) begin
      opnd_a = int_operand_i;
    end
  end

  // Only legal strobed words enter execute
  assign accept = valid_i & ~illegal_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_q <= 1'b0;
    end else begin
      ex_valid_q <= accept;
    end
  end

  // Payload, qualified by ex_valid_q
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ex_op_q       <= op_i;
      ex_a_q        <= opnd_a;
      ex_b_q        <= opnd_b;
      ex_rd_q       <= rd_i;
      ex_rd_is_fp_q <= rd_is_fp_i;
    end
  end

  assign ex_valid_o    = ex_valid_q;
  assign ex_op_o       = ex_op_q;
  assign ex_a_o        = ex_a_q;
  assign ex_b_o        = ex_b_q;
  assign ex_rd_o       = ex_rd_q;
  assign ex_rd_is_fp_o = ex_rd_is_fp_q;
  assign fwd_rf_we_o   = ex_writes_fp;

endmodule

// ==== fp_misc_unit.sv ====
/*
 * Combinational non-arithmetic FP unit
 * Sign injection, IEEE-754 2019 min/max, compares, classify, moves
 */

`timescale 1ns/1ps

module fp_misc_unit (
  input  fp_isa_pkg::fp_op_e   op_i,
  input  fp_cfg_pkg::fp_word_t a_i,
  input  fp_cfg_pkg::fp_word_t b_i,
  output fp_cfg_pkg::fp_word_t result_o
);
  import fp_cfg_pkg::*;
  import fp_isa_pkg::*;

  // One-hot class mask of a binary32 value
  function automatic logic [9:0] classify(fp_word_t v);
    logic              sgn;
    logic [EXP_W-1:0]  exp;
    logic [MANT_W-1:0] man;
    logic [9:0]        mask;
    sgn  = v[FLEN-1];
    exp  = v[FLEN-2 -: EXP_W];
    man  = v[MANT_W-1:0];
    mask = '0;
    if (exp == '1) begin
      if (man == '0) begin
        mask[sgn ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
      end else if (man[MANT_W-1]) begin
        // Quiet bit is the mantissa MSB
        mask[CLASS_QNAN] = 1'b1;
      end else begin
        mask[CLASS_SNAN] = 1'b1;
      end
    end else if (exp == '0) begin
      if (man == '0) begin
        mask[sgn ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
      end else begin
        mask[sgn ? CLASS_NEG_SUBNORM : CLASS_POS_SUBNORM] = 1'b1;
      end
    end else begin
      mask[sgn ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
    end
    return mask;
  endfunction

  logic [9:0]      class_a;
  logic [9:0]      class_b;
  logic            a_nan;
  logic            b_nan;
  logic            any_nan;
  logic            a_sgn;
  logic            b_sgn;
  logic [FLEN-2:0] a_mag;
  logic [FLEN-2:0] b_mag;
  logic            both_zero;
  logic            lt_tot;
  logic            feq;
  logic            flt;
  logic            fle;
  fp_word_t        min_res;
  fp_word_t        max_res;

  assign class_a = classify(a_i);
  assign class_b = classify(b_i);

  assign a_nan   = class_a[CLASS_SNAN] | class_a[CLASS_QNAN];
  assign b_nan   = class_b[CLASS_SNAN] | class_b[CLASS_QNAN];
  assign any_nan = a_nan | b_nan;

  assign a_sgn = a_i[FLEN-1];
  assign b_sgn = b_i[FLEN-1];
  assign a_mag = a_i[FLEN-2:0];
  assign b_mag = b_i[FLEN-2:0];

  // +0 and -0 compare equal
  assign both_zero = (a_mag == '0) && (b_mag == '0);

  // Sign-magnitude ordering with -0 below +0
  always_comb begin
    if (a_sgn != b_sgn) begin
      lt_tot = a_sgn;
    end else if (a_sgn) begin
      lt_tot = a_mag > b_mag;
    end else begin
      lt_tot = a_mag < b_mag;
    end
  end

  // Any NaN gives false
  assign feq = !any_nan && ((a_i == b_i) || both_zero);
  assign flt = !any_nan && lt_tot && !both_zero;
  assign fle = !any_nan && (lt_tot || (a_i == b_i) || both_zero);

  // A single NaN loses to the number
  always_comb begin
    if (a_nan && b_nan) begin
      min_res = CANON_NAN;
      max_res = CANON_NAN;
    end else if (a_nan) begin
      min_res = b_i;
      max_res = b_i;
    end else if (b_nan) begin
      min_res = a_i;
      max_res = a_i;
    end else begin
      min_res = lt_tot ? a_i : b_i;
      max_res = lt_tot ? b_i : a_i;
    end
  end

  always_comb begin
    case (op_i)
      OP_FSGNJ:   result_o = {b_sgn, a_mag};
      OP_FSGNJN:  result_o = {~b_sgn, a_mag};
      OP_FSGNJX:  result_o = {a_sgn ^ b_sgn, a_mag};
      OP_FMIN:    result_o = min_res;
      OP_FMAX:    result_o = max_res;
      OP_FEQ:     result_o = fp_word_t'(feq);
      OP_FLT:     result_o = fp_word_t'(flt);
      OP_FLE:     result_o = fp_word_t'(fle);
      OP_FCLASS:  result_o = fp_word_t'(class_a);
      // Raw bit moves in both directions
      OP_FMV_X_W: result_o = a_i;
      OP_FMV_W_X: result_o = a_i;
      default:    result_o = '0;
    endcase
  end

endmodule

// ==== fp_exec_top.sv ====
/*
 * Top level of the non-arithmetic FP subsystem
 * Decoder, register file, issue stage and misc unit
 */

`timescale 1ns/1ps

module fp_exec_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Instruction strobe and integer source
  input  logic                   instr_valid_i,
  input  logic [31:0]            instr_i,
  input  fp_cfg_pkg::fp_word_t   int_operand_i,

  // Debug read of architectural state
  input  fp_cfg_pkg::freg_addr_t dbg_raddr_i,
  output fp_cfg_pkg::fp_word_t   dbg_rdata_o,

  // Integer-side result
  output logic                   int_valid_o,
  output fp_cfg_pkg::freg_addr_t int_rd_o,
  output fp_cfg_pkg::fp_word_t   int_result_o,

  output logic                   illegal_o
);
  import fp_cfg_pkg::*;
  import fp_isa_pkg::*;

  // Decode
  fp_op_e     dec_op;
  freg_addr_t dec_rs1;
  freg_addr_t dec_rs2;
  freg_addr_t dec_rd;
  logic       dec_rd_is_fp;
  logic       dec_illegal;

  // RF reads
  fp_word_t   rf_a;
  fp_word_t   rf_b;

  // Execute
  logic       ex_valid;
  fp_op_e     ex_op;
  fp_word_t   ex_a;
  fp_word_t   ex_b;
  freg_addr_t ex_rd;
  logic       ex_rd_is_fp;
  logic       rf_we;
  fp_word_t   ex_result;

  fp_decoder u_decoder (
    .instr_i    (instr_i),
    .op_o       (dec_op),
    .rs1_o      (dec_rs1),
    .rs2_o      (dec_rs2),
    .rd_o       (dec_rd),
    .rd_is_fp_o (dec_rd_is_fp),
    .illegal_o  (dec_illegal)
  );

  // Port c is the debug read
  fp_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec_rs1),
    .raddr_b_i (dec_rs2),
    .raddr_c_i (dbg_raddr_i),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .rdata_c_o (dbg_rdata_o),
    .waddr_i   (ex_rd),
    .wdata_i   (ex_result),
    .we_i      (rf_we)
  );

  fp_issue_stage u_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (instr_valid_i),
    .op_i          (dec_op),
    .rs1_i         (dec_rs1),
    .rs2_i         (dec_rs2),
    .rd_i          (dec_rd),
    .rd_is_fp_i    (dec_rd_is_fp),
    .illegal_i     (dec_illegal),
    .rf_a_i        (rf_a),
    .rf_b_i        (rf_b),
    .int_operand_i (int_operand_i),
    .result_i      (ex_result),
    .ex_valid_o    (ex_valid),
    .ex_op_o       (ex_op),
    .ex_a_o        (ex_a),
    .ex_b_o        (ex_b),
    .ex_rd_o       (ex_rd),
    .ex_rd_is_fp_o (ex_rd_is_fp),
    .fwd_rf_we_o   (rf_we)
  );

  fp_misc_unit u_misc (
    .op_i     (ex_op),
    .a_i      (ex_a),
    .b_i      (ex_b),
    .result_o (ex_result)
  );

  // Integer results leave during the execute cycle
  assign int_valid_o  = ex_valid & ~ex_rd_is_fp;
  assign int_rd_o     = ex_rd;
  assign int_result_o = ex_result;
  assign illegal_o    = dec_illegal;

endmodule

// ==== tb_clk_gen.sv ====
/*
 * Testbench clock and reset source
 * 40 ns clock, active-low reset held for 10 cycles
 */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tb_fp_exec.sv ====
/*
 * Directed testbench for the non-arithmetic FP subsystem
 * Reference model of the register file and the operation rules
 * Moves, sign injection, min/max, compares, classify, forwarding, illegal words
 */

`timescale 1ns/1ps

module tb_fp_exec;
  import fp_cfg_pkg::*;
  import fp_isa_pkg::*;

  // Tests take about 900 cycles
  localparam int MAX_CYCLES = 2000;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  fp_word_t    int_operand;
  freg_addr_t  dbg_raddr;
  fp_word_t    dbg_rdata;
  logic        int_valid;
  freg_addr_t  int_rd;
  fp_word_t    int_result;
  logic        illegal;

  fp_word_t mdl [NUM_FREGS];
  fp_word_t specials [12];
  int       errors = 0;
  int       checks = 0;
  int       cycles = 0;
  integer   seed;

  tb_clk_gen u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  fp_exec_top DUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .int_operand_i (int_operand),
    .dbg_raddr_i   (dbg_raddr),
    .dbg_rdata_o   (dbg_rdata),
    .int_valid_o   (int_valid),
    .int_rd_o      (int_rd),
    .int_result_o  (int_result),
    .illegal_o     (illegal)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped, no end of test after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic is_nan(fp_word_t v);
    return (v[30:23] == 8'hff) && (v[22:0] != 23'd0);
  endfunction

  // Unsigned key in numeric order with -0 just below +0
  function automatic fp_word_t order_key(fp_word_t v);
    return v[31] ? ~v : (v | 32'h8000_0000);
  endfunction

  function automatic fp_word_t class_mask(fp_word_t v);
    if (is_nan(v)) return v[22] ? 32'h200 : 32'h100;
    if (v[30:0] == 31'h7f80_0000) return v[31] ? 32'h001 : 32'h080;
    if (v[30:0] == 31'd0) return v[31] ? 32'h008 : 32'h010;
    if (v[30:23] == 8'd0) return v[31] ? 32'h004 : 32'h020;
    return v[31] ? 32'h002 : 32'h040;
  endfunction

  function automatic fp_word_t min_max(fp_word_t a, fp_word_t b, logic want_max);
    logic a_lt_b;
    a_lt_b = order_key(a) < order_key(b);
    if (is_nan(a) && is_nan(b)) return CANON_NAN;
    if (is_nan(a)) return b;
    if (is_nan(b)) return a;
    return (a_lt_b ^ want_max) ? a : b;
  endfunction

  // Expected result of one operation on model operands
  function automatic fp_word_t model_op(fp_op_e op, fp_word_t a, fp_word_t b, fp_word_t iop);
    logic nan_in;
    logic zeros;
    nan_in = is_nan(a) || is_nan(b);
    zeros  = ((a | b) & 32'h7fff_ffff) == 32'd0;
    case (op)
      OP_FSGNJ:   return {b[31], a[30:0]};
      OP_FSGNJN:  return {~b[31], a[30:0]};
      OP_FSGNJX:  return {a[31] ^ b[31], a[30:0]};
      OP_FMIN:    return min_max(a, b, 1'b0);
      OP_FMAX:    return min_max(a, b, 1'b1);
      OP_FEQ:     return fp_word_t'(!nan_in && (a == b || zeros));
      OP_FLT:     return fp_word_t'(!nan_in && !zeros && order_key(a) < order_key(b));
      OP_FLE:     return fp_word_t'(!nan_in && (zeros || order_key(a) <= order_key(b)));
      OP_FCLASS:  return class_mask(a);
      OP_FMV_X_W: return a;
      OP_FMV_W_X: return iop;
      default:    return 32'd0;
    endcase
  endfunction

  function automatic logic writes_fp(fp_op_e op);
    return op inside {OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMIN, OP_FMAX, OP_FMV_W_X};
  endfunction

  // R-type OP-FP word with fmt S
  function automatic logic [31:0] encode(fp_op_e op, freg_addr_t rd, freg_addr_t rs1,
                                         freg_addr_t rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    freg_addr_t r2;
    case (op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: f7 = FUNCT7_SGNJ;
      OP_FMIN, OP_FMAX:               f7 = FUNCT7_MINMAX;
      OP_FEQ, OP_FLT, OP_FLE:         f7 = FUNCT7_CMP;
      OP_FCLASS, OP_FMV_X_W:          f7 = FUNCT7_MV_X_W;
      default:                        f7 = FUNCT7_MV_W_X;
    endcase
    case (op)
      OP_FSGNJN, OP_FMAX, OP_FLT, OP_FCLASS: f3 = 3'b001;
      OP_FSGNJX, OP_FEQ:                     f3 = 3'b010;
      default:                               f3 = 3'b000;
    endcase
    r2 = (op inside {OP_FCLASS, OP_FMV_X_W, OP_FMV_W_X}) ? 5'd0 : rs2;
    return {f7, r2, rs1, f3, rd, OPC_OP_FP};
  endfunction

  task automatic check_word(input string name, input fp_word_t got, input fp_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got %h exp %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_reg(input freg_addr_t idx);
    dbg_raddr = idx;
    @(negedge clk);
    check_word("dbg_rdata_o", dbg_rdata, mdl[idx]);
  endtask

  task automatic go_idle();
    instr_valid = 1'b0;
    instr       = 32'd0;
    int_operand = 32'd0;
  endtask

  // Presents one word for one cycle and returns with it in execute
  task automatic stream_op(input fp_op_e op, input freg_addr_t rd, input freg_addr_t rs1,
                           input freg_addr_t rs2, input fp_word_t iop);
    fp_word_t exp;
    exp = model_op(op, mdl[rs1], mdl[rs2], iop);
    if (writes_fp(op)) mdl[rd] = exp;
    instr_valid = 1'b1;
    instr       = encode(op, rd, rs1, rs2);
    int_operand = iop;
    // A legal word keeps illegal_o low
    @(posedge clk);
    check_word("illegal_o", fp_word_t'(illegal), 32'd0);
    @(negedge clk);
  endtask

  task automatic exec_op(input fp_op_e op, input freg_addr_t rd, input freg_addr_t rs1,
                         input freg_addr_t rs2, input fp_word_t iop);
    fp_word_t exp;
    exp = model_op(op, mdl[rs1], mdl[rs2], iop);
    stream_op(op, rd, rs1, rs2, iop);
    go_idle();
    if (writes_fp(op)) begin
      check_word("int_valid_o", fp_word_t'(int_valid), 32'd0);
      check_reg(rd);
    end else begin
      check_word("int_valid_o", fp_word_t'(int_valid), 32'd1);
      check_word("int_rd_o", fp_word_t'(int_rd), fp_word_t'(rd));
      check_word("int_result_o", int_result, exp);
      // One-cycle pulse only
      @(negedge clk);
      check_word("int_valid_o", fp_word_t'(int_valid), 32'd0);
    end
  endtask

  task automatic test_reset();
    for (int i = 0; i < NUM_FREGS; i++) check_reg(freg_addr_t'(i));
    repeat (4) begin
      @(negedge clk);
      check_word("int_valid_o", fp_word_t'(int_valid), 32'd0);
    end
  endtask

  task automatic test_moves();
    for (int i = 0; i < NUM_FREGS; i++) begin
      exec_op(OP_FMV_W_X, freg_addr_t'(i), freg_addr_t'(31 - i), 5'd0, $random(seed));
    end
    for (int i = 0; i < NUM_FREGS; i++) begin
      exec_op(OP_FMV_X_W, freg_addr_t'(31 - i), freg_addr_t'(i), 5'd0, 32'd0);
    end
  endtask

  // Special values in f0..f11 and random values in f12..f19
  task automatic load_operands();
    for (int i = 0; i < 12; i++) begin
      exec_op(OP_FMV_W_X, freg_addr_t'(i), 5'd0, 5'd0, specials[i]);
    end
    for (int i = 12; i < 20; i++) begin
      exec_op(OP_FMV_W_X, freg_addr_t'(i), 5'd0, 5'd0, $random(seed));
    end
  endtask

  task automatic test_sign_inject();
    fp_op_e op;
    for (int k = 0; k < 3; k++) begin
      case (k)
        0:       op = OP_FSGNJ;
        1:       op = OP_FSGNJN;
        default: op = OP_FSGNJX;
      endcase
      for (int i = 0; i < 12; i++) begin
        exec_op(op, freg_addr_t'(20 + i), freg_addr_t'((i * 7 + k) % 20),
                freg_addr_t'($unsigned($random(seed)) % 20), 32'd0);
      end
    end
  endtask

  task automatic test_min_max_cmp();
    fp_op_e op;
    int     j;
    for (int k = 0; k < 5; k++) begin
      case (k)
        0:       op = OP_FMIN;
        1:       op = OP_FMAX;
        2:       op = OP_FEQ;
        3:       op = OP_FLT;
        default: op = OP_FLE;
      endcase
      // Pair with itself, both neighbours and the opposite entry
      for (int i = 0; i < 12; i++) begin
        for (int d = 0; d < 4; d++) begin
          j = (d == 0) ? i : (d == 1) ? (i + 1) % 12 : (d == 2) ? (i + 11) % 12 : (i + 6) % 12;
          exec_op(op, freg_addr_t'(20 + i), freg_addr_t'(i), freg_addr_t'(j), 32'd0);
        end
      end
    end
    for (int i = 0; i < 20; i++) begin
      exec_op(OP_FCLASS, freg_addr_t'(i), freg_addr_t'(i), 5'd0, 32'd0);
    end
  endtask

  task automatic test_forwarding();
    fp_op_e     op;
    freg_addr_t rd;
    stream_op(OP_FSGNJN, 5'd21, 5'd10, 5'd10, 32'd0);
    // rd equal to both sources
    stream_op(OP_FSGNJX, 5'd21, 5'd21, 5'd21, 32'd0);
    stream_op(OP_FMAX, 5'd22, 5'd21, 5'd11, 32'd0);
    stream_op(OP_FMIN, 5'd21, 5'd22, 5'd21, 32'd0);
    // Integer source wins over a bypass hit on rs1
    stream_op(OP_FMV_W_X, 5'd23, 5'd21, 5'd0, $random(seed));
    stream_op(OP_FSGNJ, 5'd24, 5'd12, 5'd23, 32'd0);
    repeat (16) begin
      case ($unsigned($random(seed)) % 4)
        0:       op = OP_FSGNJN;
        1:       op = OP_FSGNJX;
        2:       op = OP_FMIN;
        default: op = OP_FMAX;
      endcase
      rd = freg_addr_t'(20 + $unsigned($random(seed)) % 4);
      stream_op(op, rd, freg_addr_t'(20 + $unsigned($random(seed)) % 4),
                freg_addr_t'(20 + $unsigned($random(seed)) % 4), 32'd0);
    end
    // Integer result from a forwarded operand
    exec_op(OP_FLE, 5'd3, rd, rd, 32'd0);
    for (int i = 20; i < 25; i++) check_reg(freg_addr_t'(i));
  endtask

  task automatic test_illegal();
    logic [31:0] bad [4];
    bad[0] = encode(OP_FSGNJ, 5'd22, 5'd0, 5'd1) | 32'h0200_0000;
    bad[1] = encode(OP_FCLASS, 5'd3, 5'd4, 5'd0) | (32'd3 << 20);
    bad[2] = encode(OP_FMIN, 5'd22, 5'd2, 5'd3) | (32'd2 << 12);
    bad[3] = encode(OP_FMV_W_X, 5'd22, 5'd1, 5'd0) | (32'd1 << 20);
    for (int i = 0; i < 4; i++) begin
      instr_valid = 1'b1;
      instr       = bad[i];
      int_operand = $random(seed);
      @(posedge clk);
      check_word("illegal_o", fp_word_t'(illegal), 32'd1);
      @(negedge clk);
      go_idle();
      check_word("int_valid_o", fp_word_t'(int_valid), 32'd0);
      check_reg(5'd22);
      check_word("int_valid_o", fp_word_t'(int_valid), 32'd0);
    end
  endtask

  initial begin
    seed      = 32'h80f0;
    dbg_raddr = 5'd0;
    go_idle();
    for (int i = 0; i < NUM_FREGS; i++) mdl[i] = 32'd0;
    specials[0]  = 32'h0000_0000;
    specials[1]  = 32'h8000_0000;
    specials[2]  = 32'h7f80_0000;
    specials[3]  = 32'hff80_0000;
    specials[4]  = 32'h7fc0_0000;
    specials[5]  = 32'hffc0_0001;
    specials[6]  = 32'h7f80_0001;
    specials[7]  = 32'hffa0_0000;
    specials[8]  = 32'h0000_0001;
    specials[9]  = 32'h807f_ffff;
    specials[10] = 32'h3f80_0000;
    specials[11] = 32'hc000_0000;
    @(posedge rst_n);
    @(negedge clk);
    test_reset();
    test_moves();
    load_operands();
    test_sign_inject();
    test_min_max_cmp();
    test_forwarding();
    test_illegal();
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
fp_cfg_pkg.sv
fp_isa_pkg.sv
fp_regfile.sv
fp_decoder.sv
fp_issue_stage.sv
fp_misc_unit.sv
fp_exec_top.sv
tb_clk_gen.sv
tb_fp_exec.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result decided from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_fp_exec -o sim_fp_exec
./obj_dir/sim_fp_exec > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
